/* logic/prf_wb_pkg.sv */
// shared sizes and types for the register file writeback path, used by RTL and testbench
package prf_wb_pkg;

    // ------------------------------
    // sizes

    localparam int WR_COUNT = 4;
    localparam int BANK_COUNT = 4;
    localparam int LOG_BANK_COUNT = $clog2(BANK_COUNT);
    localparam int PR_COUNT = 64;
    localparam int LOG_PR_COUNT = $clog2(PR_COUNT);
    localparam int UPPER_PR_WIDTH = LOG_PR_COUNT - LOG_BANK_COUNT;
    localparam int ROB_INDEX_WIDTH = 7;
    localparam int DATA_WIDTH = 32;

    // ------------------------------
    // payload types

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [UPPER_PR_WIDTH-1:0] upper_pr_t;
    typedef logic [ROB_INDEX_WIDTH-1:0] rob_index_t;

    // one bit per writer
    typedef logic [WR_COUNT-1:0] wr_vec_t;

    // ------------------------------
    // physical register number

    // bank sits in the low bits so consecutive registers spread over banks
    typedef struct packed {
        upper_pr_t                  upper;
        logic [LOG_BANK_COUNT-1:0]  bank;
    } pr_fields_t;

    // flat number for the writers, split view for the banks
    typedef union packed {
        logic [LOG_PR_COUNT-1:0]    num;
        pr_fields_t                 fields;
    } pr_u;

endpackage

/* logic/wb_req_if.sv */
// per-writer writeback requests passed from the hold stage to every bank arbiter and driver
`timescale 1ns/1ps

interface wb_req_if;

    // one entry per writer, bank not yet decoded
    prf_wb_pkg::wr_vec_t                                        req_valid;
    prf_wb_pkg::pr_u [prf_wb_pkg::WR_COUNT-1:0]                 req_pr;
    prf_wb_pkg::data_t [prf_wb_pkg::WR_COUNT-1:0]               req_data;
    prf_wb_pkg::rob_index_t [prf_wb_pkg::WR_COUNT-1:0]          req_rob_index;

    // hold stage side
    modport source (
        output req_valid,
        output req_pr,
        output req_data,
        output req_rob_index
    );

    // bank side, each bank filters by its own bank field
    modport sink (
        input req_valid,
        input req_pr,
        input req_data,
        input req_rob_index
    );

endinterface

/* logic/wb_hold_stage.sv */
// keeps one losing writeback per writer and presents held or new requests to the banks
`timescale 1ns/1ps

module wb_hold_stage (
    input  logic                                                CLK,
    input  logic                                                nRST,

    // new writeback per writer
    input  prf_wb_pkg::wr_vec_t                                 wb_valid,
    input  prf_wb_pkg::pr_u [prf_wb_pkg::WR_COUNT-1:0]          wb_pr,
    input  prf_wb_pkg::data_t [prf_wb_pkg::WR_COUNT-1:0]        wb_data,
    input  prf_wb_pkg::rob_index_t [prf_wb_pkg::WR_COUNT-1:0]   wb_rob_index,

    // grants from every bank arbiter
    input  prf_wb_pkg::wr_vec_t [prf_wb_pkg::BANK_COUNT-1:0]    grant_by_bank,

    wb_req_if.source                                            req,

    output prf_wb_pkg::wr_vec_t                                 ready
);

    prf_wb_pkg::wr_vec_t                                held_valid;
    prf_wb_pkg::wr_vec_t                                next_held_valid;
    prf_wb_pkg::wr_vec_t                                grant_any;
    prf_wb_pkg::wr_vec_t                                hold_en;
    prf_wb_pkg::pr_u [prf_wb_pkg::WR_COUNT-1:0]         held_pr;
    prf_wb_pkg::data_t [prf_wb_pkg::WR_COUNT-1:0]       held_data;
    prf_wb_pkg::rob_index_t [prf_wb_pkg::WR_COUNT-1:0]  held_rob_index;

    // ------------------------------
    // request selection

    // held entry wins, new input while held is dropped
    always_comb begin
        for (int w = 0; w < prf_wb_pkg::WR_COUNT; w++) begin
            if (held_valid[w]) begin
                req.req_valid[w] = 1'b1;
                req.req_pr[w] = held_pr[w];
                req.req_data[w] = held_data[w];
                req.req_rob_index[w] = held_rob_index[w];
            end
            else begin
                req.req_valid[w] = wb_valid[w];
                req.req_pr[w] = wb_pr[w];
                req.req_data[w] = wb_data[w];
                req.req_rob_index[w] = wb_rob_index[w];
            end
        end
    end

    // ------------------------------
    // grant collection and hold decision

    // a writer targets one bank, so at most one of these bits is set per writer
    always_comb begin
        grant_any = '0;
        for (int b = 0; b < prf_wb_pkg::BANK_COUNT; b++) begin
            grant_any |= grant_by_bank[b];
        end
    end

    assign hold_en = req.req_valid & ~grant_any;
    assign next_held_valid = hold_en;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            held_valid <= '0;
        end
        else begin
            held_valid <= next_held_valid;
        end
    end

    // payload captured only for losers
    always_ff @(posedge CLK) begin
        for (int w = 0; w < prf_wb_pkg::WR_COUNT; w++) begin
            if (hold_en[w]) begin
                held_pr[w] <= req.req_pr[w];
                held_data[w] <= req.req_data[w];
                held_rob_index[w] <= req.req_rob_index[w];
            end
        end
    end

    // level ready, straight from the held flag
    assign ready = ~held_valid;

endmodule

/* logic/wb_bank_arbiter.sv */
// per-bank writer arbiter, picks one writeback per cycle with a last-grant mask for fairness
`timescale 1ns/1ps

module wb_bank_arbiter #(
    parameter int BANK_INDEX = 0
) (
    input  logic                    CLK,
    input  logic                    nRST,

    wb_req_if.sink                  req,

    output prf_wb_pkg::wr_vec_t     grant
);

    prf_wb_pkg::wr_vec_t bank_req;
    prf_wb_pkg::wr_vec_t masked_req;
    prf_wb_pkg::wr_vec_t last_mask;
    prf_wb_pkg::wr_vec_t next_mask;

    // one-hot of the highest-numbered set bit
    function automatic prf_wb_pkg::wr_vec_t pick_highest(input prf_wb_pkg::wr_vec_t vec);
        prf_wb_pkg::wr_vec_t onehot;
        onehot = '0;
        // upward scan, the top bit gets the last word
        for (int w = 0; w < prf_wb_pkg::WR_COUNT; w++) begin
            if (vec[w]) begin
                onehot = '0;
                onehot[w] = 1'b1;
            end
        end
        return onehot;
    endfunction

    // ------------------------------
    // requests for this bank

    always_comb begin
        for (int w = 0; w < prf_wb_pkg::WR_COUNT; w++) begin
            bank_req[w] = req.req_valid[w]
                & (int'(req.req_pr[w].fields.bank) == BANK_INDEX);
        end
    end

    assign masked_req = bank_req & last_mask;

    // ------------------------------
    // pick and mask update

    always_comb begin
        if (|masked_req) begin
            grant = pick_highest(masked_req);
        end
        else begin
            grant = pick_highest(bank_req);
        end

        // writers below this cycle's winner go first next time
        next_mask = '0;
        for (int w = prf_wb_pkg::WR_COUNT - 2; w >= 0; w--) begin
            next_mask[w] = grant[w+1] | next_mask[w+1];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            last_mask <= '0;
        end
        else begin
            last_mask <= next_mask;
        end
    end

endmodule

/* logic/wb_bank_driver.sv */
// per-bank writeback bus registers fed by the granted writer, plus the delayed forward data
`timescale 1ns/1ps

module wb_bank_driver #(
    parameter int BANK_INDEX = 0
) (
    input  logic                        CLK,
    input  logic                        nRST,

    wb_req_if.sink                      req,
    input  prf_wb_pkg::wr_vec_t         grant,

    // writeback bus
    output logic                        bus_valid,
    output prf_wb_pkg::data_t           bus_data,
    output prf_wb_pkg::upper_pr_t       bus_upper_pr,
    output prf_wb_pkg::rob_index_t      bus_rob_index,

    output prf_wb_pkg::data_t           forward_data
);

    prf_wb_pkg::wr_vec_t        bank_hit;
    prf_wb_pkg::wr_vec_t        sel;
    logic                       next_valid;
    prf_wb_pkg::data_t          next_data;
    prf_wb_pkg::upper_pr_t      next_upper_pr;
    prf_wb_pkg::rob_index_t     next_rob_index;

    // ------------------------------
    // one-hot select

    always_comb begin
        for (int w = 0; w < prf_wb_pkg::WR_COUNT; w++) begin
            bank_hit[w] = req.req_valid[w]
                & (int'(req.req_pr[w].fields.bank) == BANK_INDEX);
        end
        sel = grant & bank_hit;

        // and-or mux, zero when nothing granted
        next_data = '0;
        next_upper_pr = '0;
        next_rob_index = '0;
        for (int w = 0; w < prf_wb_pkg::WR_COUNT; w++) begin
            next_data |= req.req_data[w] & {prf_wb_pkg::DATA_WIDTH{sel[w]}};
            next_upper_pr |= req.req_pr[w].fields.upper
                & {prf_wb_pkg::UPPER_PR_WIDTH{sel[w]}};
            next_rob_index |= req.req_rob_index[w]
                & {prf_wb_pkg::ROB_INDEX_WIDTH{sel[w]}};
        end

        next_valid = |sel;

        // register 0 lives only in bank 0 at upper index 0
        // granted but never advertised
        if (BANK_INDEX == 0 && next_upper_pr == '0) begin
            next_valid = 1'b0;
        end
    end

    // ------------------------------
    // bus and forward registers

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            bus_valid <= 1'b0;
            bus_data <= '0;
            bus_upper_pr <= '0;
            bus_rob_index <= '0;
            forward_data <= '0;
        end
        else begin
            bus_valid <= next_valid;
            bus_data <= next_data;
            bus_upper_pr <= next_upper_pr;
            bus_rob_index <= next_rob_index;
            // one cycle behind the bus, taken every cycle
            forward_data <= bus_data;
        end
    end

endmodule

/* logic/prf_wb_top.sv */
// top of the banked register file writeback path, hold stage plus one arbiter and driver per bank
`timescale 1ns/1ps

module prf_wb_top (
    input  logic                                                    CLK,
    input  logic                                                    nRST,

    // writeback requests by writer
    input  prf_wb_pkg::wr_vec_t                                     wb_valid_by_wr,
    input  prf_wb_pkg::pr_u [prf_wb_pkg::WR_COUNT-1:0]              wb_pr_by_wr,
    input  prf_wb_pkg::data_t [prf_wb_pkg::WR_COUNT-1:0]            wb_data_by_wr,
    input  prf_wb_pkg::rob_index_t [prf_wb_pkg::WR_COUNT-1:0]       wb_rob_index_by_wr,

    // back-pressure by writer
    output prf_wb_pkg::wr_vec_t                                     wb_ready_by_wr,

    // writeback bus by bank
    output logic [prf_wb_pkg::BANK_COUNT-1:0]                       wb_bus_valid_by_bank,
    output prf_wb_pkg::data_t [prf_wb_pkg::BANK_COUNT-1:0]          wb_bus_data_by_bank,
    output prf_wb_pkg::upper_pr_t [prf_wb_pkg::BANK_COUNT-1:0]      wb_bus_upper_pr_by_bank,
    output prf_wb_pkg::rob_index_t [prf_wb_pkg::BANK_COUNT-1:0]     wb_bus_rob_index_by_bank,

    // forward data by bank
    output prf_wb_pkg::data_t [prf_wb_pkg::BANK_COUNT-1:0]          forward_data_by_bank
);

    prf_wb_pkg::wr_vec_t [prf_wb_pkg::BANK_COUNT-1:0] grant_by_bank;

    wb_req_if req_bus ();

    // ------------------------------
    // writer side

    wb_hold_stage hold_stage_inst (
        .CLK            (CLK),
        .nRST           (nRST),
        .wb_valid       (wb_valid_by_wr),
        .wb_pr          (wb_pr_by_wr),
        .wb_data        (wb_data_by_wr),
        .wb_rob_index   (wb_rob_index_by_wr),
        .grant_by_bank  (grant_by_bank),
        .req            (req_bus.source),
        .ready          (wb_ready_by_wr)
    );

    // ------------------------------
    // bank side

    for (genvar b = 0; b < prf_wb_pkg::BANK_COUNT; b++) begin : gen_bank

        wb_bank_arbiter #(
            .BANK_INDEX (b)
        ) arbiter_inst (
            .CLK    (CLK),
            .nRST   (nRST),
            .req    (req_bus.sink),
            .grant  (grant_by_bank[b])
        );

        wb_bank_driver #(
            .BANK_INDEX (b)
        ) driver_inst (
            .CLK            (CLK),
            .nRST           (nRST),
            .req            (req_bus.sink),
            .grant          (grant_by_bank[b]),
            .bus_valid      (wb_bus_valid_by_bank[b]),
            .bus_data       (wb_bus_data_by_bank[b]),
            .bus_upper_pr   (wb_bus_upper_pr_by_bank[b]),
            .bus_rob_index  (wb_bus_rob_index_by_bank[b]),
            .forward_data   (forward_data_by_bank[b])
        );

    end

endmodule

/* verification/prf_wb_model.svh */
// cycle model of the writeback path, included by the testbench and advanced once per clock
`ifndef PRF_WB_MODEL_SVH
`define PRF_WB_MODEL_SVH

// predicted register state, mirrors what the DUT should hold
prf_wb_pkg::wr_vec_t                                    m_held_valid;
prf_wb_pkg::pr_u [prf_wb_pkg::WR_COUNT-1:0]             m_held_pr;
prf_wb_pkg::data_t [prf_wb_pkg::WR_COUNT-1:0]           m_held_data;
prf_wb_pkg::rob_index_t [prf_wb_pkg::WR_COUNT-1:0]      m_held_rob_index;
prf_wb_pkg::wr_vec_t [prf_wb_pkg::BANK_COUNT-1:0]       m_mask;
logic [prf_wb_pkg::BANK_COUNT-1:0]                      m_bus_valid;
prf_wb_pkg::data_t [prf_wb_pkg::BANK_COUNT-1:0]         m_bus_data;
prf_wb_pkg::upper_pr_t [prf_wb_pkg::BANK_COUNT-1:0]     m_bus_upper_pr;
prf_wb_pkg::rob_index_t [prf_wb_pkg::BANK_COUNT-1:0]    m_bus_rob_index;
prf_wb_pkg::data_t [prf_wb_pkg::BANK_COUNT-1:0]         m_forward_data;

task automatic reset_model();
    m_held_valid = '0;
    m_held_pr = '0;
    m_held_data = '0;
    m_held_rob_index = '0;
    m_mask = '0;
    m_bus_valid = '0;
    m_bus_data = '0;
    m_bus_upper_pr = '0;
    m_bus_rob_index = '0;
    m_forward_data = '0;
endtask

// one clock edge, inputs are the values the writers present this cycle
task automatic advance_model(
    input prf_wb_pkg::wr_vec_t                                  in_valid,
    input prf_wb_pkg::pr_u [prf_wb_pkg::WR_COUNT-1:0]           in_pr,
    input prf_wb_pkg::data_t [prf_wb_pkg::WR_COUNT-1:0]         in_data,
    input prf_wb_pkg::rob_index_t [prf_wb_pkg::WR_COUNT-1:0]    in_rob_index
);
    prf_wb_pkg::wr_vec_t                                p_valid;
    prf_wb_pkg::pr_u [prf_wb_pkg::WR_COUNT-1:0]         p_pr;
    prf_wb_pkg::data_t [prf_wb_pkg::WR_COUNT-1:0]       p_data;
    prf_wb_pkg::rob_index_t [prf_wb_pkg::WR_COUNT-1:0]  p_rob_index;
    prf_wb_pkg::wr_vec_t                                bank_req;
    prf_wb_pkg::wr_vec_t                                pick;
    prf_wb_pkg::wr_vec_t                                granted;
    int                                                 win;

    // held entry beats new input
    for (int w = 0; w < prf_wb_pkg::WR_COUNT; w++) begin
        p_valid[w] = m_held_valid[w] | in_valid[w];
        p_pr[w] = m_held_valid[w] ? m_held_pr[w] : in_pr[w];
        p_data[w] = m_held_valid[w] ? m_held_data[w] : in_data[w];
        p_rob_index[w] = m_held_valid[w] ? m_held_rob_index[w] : in_rob_index[w];
    end

    granted = '0;
    for (int b = 0; b < prf_wb_pkg::BANK_COUNT; b++) begin
        bank_req = '0;
        win = -1;
        for (int w = 0; w < prf_wb_pkg::WR_COUNT; w++) begin
            if (p_valid[w] && int'(p_pr[w].fields.bank) == b) begin
                bank_req[w] = 1'b1;
            end
        end
        // masked writers first, otherwise anyone in the bank
        pick = ((bank_req & m_mask[b]) != '0) ? (bank_req & m_mask[b]) : bank_req;
        for (int w = prf_wb_pkg::WR_COUNT - 1; w >= 0; w--) begin
            if (pick[w] && win < 0) begin
                win = w;
            end
        end

        m_forward_data[b] = m_bus_data[b];
        m_mask[b] = '0;
        m_bus_valid[b] = 1'b0;
        m_bus_data[b] = '0;
        m_bus_upper_pr[b] = '0;
        m_bus_rob_index[b] = '0;
        if (win >= 0) begin
            granted[win] = 1'b1;
            for (int w = 0; w < win; w++) begin
                m_mask[b][w] = 1'b1;
            end
            // register 0 retires without a bus valid
            m_bus_valid[b] = (p_pr[win].num != '0);
            m_bus_data[b] = p_data[win];
            m_bus_upper_pr[b] = p_pr[win].fields.upper;
            m_bus_rob_index[b] = p_rob_index[win];
        end
    end

    // losers keep what they presented
    for (int w = 0; w < prf_wb_pkg::WR_COUNT; w++) begin
        m_held_valid[w] = p_valid[w] & ~granted[w];
        if (m_held_valid[w]) begin
            m_held_pr[w] = p_pr[w];
            m_held_data[w] = p_data[w];
            m_held_rob_index[w] = p_rob_index[w];
        end
    end
endtask

`endif

/* verification/tb_prf_wb.sv */
// testbench for the writeback path, random writers checked every cycle against a cycle model
`timescale 1ns/1ps

module tb_prf_wb;

    localparam int RUN_CYCLES = 2000;
    localparam int RESET_CYCLES = 5;
    localparam int RELEASE_LIMIT = 20;
    localparam int DRAIN_LIMIT = 50;

    typedef logic [prf_wb_pkg::LOG_BANK_COUNT-1:0] bank_t;

    logic CLK = 1'b0;
    logic nRST;

    prf_wb_pkg::wr_vec_t                                    wb_valid_by_wr;
    prf_wb_pkg::pr_u [prf_wb_pkg::WR_COUNT-1:0]             wb_pr_by_wr;
    prf_wb_pkg::data_t [prf_wb_pkg::WR_COUNT-1:0]           wb_data_by_wr;
    prf_wb_pkg::rob_index_t [prf_wb_pkg::WR_COUNT-1:0]      wb_rob_index_by_wr;
    prf_wb_pkg::wr_vec_t                                    wb_ready_by_wr;
    logic [prf_wb_pkg::BANK_COUNT-1:0]                      wb_bus_valid_by_bank;
    prf_wb_pkg::data_t [prf_wb_pkg::BANK_COUNT-1:0]         wb_bus_data_by_bank;
    prf_wb_pkg::upper_pr_t [prf_wb_pkg::BANK_COUNT-1:0]     wb_bus_upper_pr_by_bank;
    prf_wb_pkg::rob_index_t [prf_wb_pkg::BANK_COUNT-1:0]    wb_bus_rob_index_by_bank;
    prf_wb_pkg::data_t [prf_wb_pkg::BANK_COUNT-1:0]         forward_data_by_bank;

    `include "prf_wb_model.svh"

    prf_wb_top prf_wb_top_inst (
        .CLK                        (CLK),
        .nRST                       (nRST),
        .wb_valid_by_wr             (wb_valid_by_wr),
        .wb_pr_by_wr                (wb_pr_by_wr),
        .wb_data_by_wr              (wb_data_by_wr),
        .wb_rob_index_by_wr         (wb_rob_index_by_wr),
        .wb_ready_by_wr             (wb_ready_by_wr),
        .wb_bus_valid_by_bank       (wb_bus_valid_by_bank),
        .wb_bus_data_by_bank        (wb_bus_data_by_bank),
        .wb_bus_upper_pr_by_bank    (wb_bus_upper_pr_by_bank),
        .wb_bus_rob_index_by_bank   (wb_bus_rob_index_by_bank),
        .forward_data_by_bank       (forward_data_by_bank)
    );

    always #5 CLK = ~CLK;

    // ------------------------------
    // compares

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_ready(input prf_wb_pkg::wr_vec_t got, input prf_wb_pkg::wr_vec_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("mismatch wb_ready_by_wr got 0x%h expected 0x%h",
                got, exp));
        end
    endtask

    task automatic check_bus(
        input int                       bank,
        input logic                     got_valid,
        input logic                     exp_valid,
        input prf_wb_pkg::data_t        got_data,
        input prf_wb_pkg::data_t        exp_data,
        input prf_wb_pkg::upper_pr_t    got_upper_pr,
        input prf_wb_pkg::upper_pr_t    exp_upper_pr,
        input prf_wb_pkg::rob_index_t   got_rob_index,
        input prf_wb_pkg::rob_index_t   exp_rob_index
    );
        if (got_valid !== exp_valid) begin
            stop_with_failure($sformatf("mismatch wb_bus_valid_by_bank[%0d] got 0x%h expected 0x%h",
                bank, got_valid, exp_valid));
        end
        else if (got_data !== exp_data) begin
            stop_with_failure($sformatf("mismatch wb_bus_data_by_bank[%0d] got 0x%h expected 0x%h",
                bank, got_data, exp_data));
        end
        else if (got_upper_pr !== exp_upper_pr) begin
            stop_with_failure($sformatf(
                "mismatch wb_bus_upper_pr_by_bank[%0d] got 0x%h expected 0x%h",
                bank, got_upper_pr, exp_upper_pr));
        end
        else if (got_rob_index !== exp_rob_index) begin
            stop_with_failure($sformatf(
                "mismatch wb_bus_rob_index_by_bank[%0d] got 0x%h expected 0x%h",
                bank, got_rob_index, exp_rob_index));
        end
    endtask

    task automatic check_forward(input int bank, input prf_wb_pkg::data_t got,
                                 input prf_wb_pkg::data_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("mismatch forward_data_by_bank[%0d] got 0x%h expected 0x%h",
                bank, got, exp));
        end
    endtask

    task automatic compare_outputs();
        check_ready(wb_ready_by_wr, ~m_held_valid);
        for (int b = 0; b < prf_wb_pkg::BANK_COUNT; b++) begin
            check_bus(b, wb_bus_valid_by_bank[b], m_bus_valid[b],
                wb_bus_data_by_bank[b], m_bus_data[b],
                wb_bus_upper_pr_by_bank[b], m_bus_upper_pr[b],
                wb_bus_rob_index_by_bank[b], m_bus_rob_index[b]);
            check_forward(b, forward_data_by_bank[b], m_forward_data[b]);
        end
    endtask

    // ------------------------------
    // stimulus

    // register 0 and banks 0 and 1 come up often so writers collide
    function automatic prf_wb_pkg::pr_u random_pr();
        prf_wb_pkg::pr_u pr;
        int unsigned kind;
        kind = $urandom % 8;
        pr.fields.upper = prf_wb_pkg::upper_pr_t'($urandom);
        pr.fields.bank = bank_t'($urandom);
        if (kind == 0) begin
            pr.num = '0;
        end
        else if (kind < 5) begin
            pr.fields.bank = bank_t'(kind % 2);
        end
        return pr;
    endfunction

    task automatic drive_writers(input prf_wb_pkg::wr_vec_t ready_prev);
        prf_wb_pkg::wr_vec_t                                next_valid;
        prf_wb_pkg::pr_u [prf_wb_pkg::WR_COUNT-1:0]         next_pr;
        prf_wb_pkg::data_t [prf_wb_pkg::WR_COUNT-1:0]       next_data;
        prf_wb_pkg::rob_index_t [prf_wb_pkg::WR_COUNT-1:0]  next_rob_index;
        next_valid = wb_valid_by_wr;
        next_pr = wb_pr_by_wr;
        next_data = wb_data_by_wr;
        next_rob_index = wb_rob_index_by_wr;
        for (int w = 0; w < prf_wb_pkg::WR_COUNT; w++) begin
            if (ready_prev[w] || ($urandom % 4 == 0)) begin
                // a stalled writer changing its request here must be dropped
                next_valid[w] = ready_prev[w] ? (($urandom % 10) < 7) : 1'b1;
                next_pr[w] = random_pr();
                next_data[w] = prf_wb_pkg::data_t'($urandom);
                next_rob_index[w] = prf_wb_pkg::rob_index_t'($urandom);
            end
        end
        wb_valid_by_wr <= next_valid;
        wb_pr_by_wr <= next_pr;
        wb_data_by_wr <= next_data;
        wb_rob_index_by_wr <= next_rob_index;
    endtask

    // check at the falling edge, drive at the rising edge
    task automatic run_cycle(input logic active, output prf_wb_pkg::wr_vec_t ready_seen);
        @(negedge CLK);
        compare_outputs();
        advance_model(wb_valid_by_wr, wb_pr_by_wr, wb_data_by_wr, wb_rob_index_by_wr);
        ready_seen = wb_ready_by_wr;
        @(posedge CLK);
        if (active) begin
            drive_writers(ready_seen);
        end
        else begin
            wb_valid_by_wr <= '0;
        end
    endtask

    // ------------------------------
    // main sequence

    initial begin
        int waited;
        prf_wb_pkg::wr_vec_t ready_now;
        void'($urandom(61370));
        reset_model();
        nRST <= 1'b0;
        wb_valid_by_wr <= '0;
        wb_pr_by_wr <= '0;
        wb_data_by_wr <= '0;
        wb_rob_index_by_wr <= '0;

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge CLK);
            compare_outputs();
            @(posedge CLK);
        end
        nRST <= 1'b1;

        waited = 0;
        while (nRST !== 1'b1) begin
            if (waited == RELEASE_LIMIT) begin
                stop_with_failure("timeout waiting for reset to be released");
            end
            else begin
                @(posedge CLK);
                waited++;
            end
        end

        for (int c = 0; c < RUN_CYCLES; c++) begin
            run_cycle(1'b1, ready_now);
        end

        // writers go quiet, the DUT must raise every ready again
        waited = 0;
        ready_now = '0;
        while (ready_now !== '1) begin
            if (waited == DRAIN_LIMIT) begin
                stop_with_failure("timeout waiting for held writebacks to drain");
            end
            else begin
                run_cycle(1'b0, ready_now);
                waited++;
            end
        end
        run_cycle(1'b0, ready_now);

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+verification
logic/prf_wb_pkg.sv
logic/wb_req_if.sv
logic/wb_hold_stage.sv
logic/wb_bank_arbiter.sv
logic/wb_bank_driver.sv
logic/prf_wb_top.sv
verification/tb_prf_wb.sv

/* Makefile */
SIM := obj_dir/Vtb_prf_wb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): flist.f $(wildcard logic/*.sv) $(wildcard verification/*.sv verification/*.svh)
	verilator --binary --top-module tb_prf_wb -f flist.f -Mdir obj_dir

# the log decides pass or fail
run: $(SIM)
	-$(SIM) > sim.log 2>&1
	@cat sim.log
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
